/* design/cpu_macros.svh */
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

// data path width, accumulator and memory words
`define CPU_DATA_W 16

// address width shared by both memories and the pc
`define CPU_ADDR_W 12

// words per memory array
`define CPU_MEM_DEPTH 4096

// immediate field width in the alu instruction format
`define CPU_IMM_W 8

// opcode and alu function field width
`define CPU_OP_W 4

`endif

/* design/cpu_pkg.sv */
`include "cpu_macros.svh"

package cpu_pkg;

    // instruction classes where codes 9..15 decode to nop
    typedef enum logic [`CPU_OP_W-1:0] {
        OP_NOP   = 4'd0,
        OP_ALUI  = 4'd1,
        OP_ALUB  = 4'd2,
        OP_LOAD  = 4'd3,
        OP_LDB   = 4'd4,
        OP_STORE = 4'd5,
        OP_JMP   = 4'd6,
        OP_JZ    = 4'd7,
        OP_HALT  = 4'd8
    } opcode_e;

    // alu functions in order from add through eq
    typedef enum logic [`CPU_OP_W-1:0] {
        ALU_ADD, ALU_SUB, ALU_MUL, ALU_DIV,
        ALU_SHL, ALU_SHR, ALU_ROL, ALU_ROR,
        ALU_AND, ALU_OR, ALU_XOR, ALU_NOR,
        ALU_NAND, ALU_XNOR, ALU_GT, ALU_EQ
    } alu_op_e;

    // prog port memory select
    localparam logic PROG_IMEM = 1'b0;
    localparam logic PROG_DMEM = 1'b1;

    // alu format with opcode, function and 8-bit immediate
    typedef struct packed {
        opcode_e                opcode;
        alu_op_e                func;
        logic [`CPU_IMM_W-1:0]  imm;
    } imm_fmt_t;

    // memory and jump format with opcode and 12-bit address
    typedef struct packed {
        opcode_e                opcode;
        logic [`CPU_ADDR_W-1:0] addr;
    } addr_fmt_t;

    // one word read two ways with the opcode picking the view
    typedef union packed {
        imm_fmt_t  imm;
        addr_fmt_t addr;
    } instr_t;

    typedef struct packed {
        logic                   valid;
        logic [`CPU_ADDR_W-1:0] pc;
        instr_t                 instr;
    } fetch_t;

    typedef struct packed {
        logic                   valid;
        opcode_e                opcode;
        alu_op_e                func;
        logic [`CPU_DATA_W-1:0] operand;
        logic [`CPU_ADDR_W-1:0] pc;
    } exec_cmd_t;

    typedef struct packed {
        logic                   done;
        logic                   taken;
        logic [`CPU_ADDR_W-1:0] target;
    } redirect_t;

    typedef struct packed {
        logic                   we;
        logic                   target;
        logic [`CPU_ADDR_W-1:0] addr;
        logic [`CPU_DATA_W-1:0] data;
    } prog_wr_t;

    typedef struct packed {
        logic                   valid;
        logic [`CPU_ADDR_W-1:0] addr;
        logic [`CPU_DATA_W-1:0] data;
    } store_t;

endpackage

/* design/fetch_unit.sv */
`timescale 1ns/1ps
`include "cpu_macros.svh"

module fetch_unit (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               run,
    input  logic               halted,
    input  cpu_pkg::redirect_t redir,
    input  cpu_pkg::prog_wr_t  prog,
    output cpu_pkg::fetch_t    fetch
);
    import cpu_pkg::*;

    logic [`CPU_DATA_W-1:0] imem [`CPU_MEM_DEPTH];
    logic [`CPU_ADDR_W-1:0] pc;
    // high from read issue until execute reports done
    logic                   wait_done;
    logic                   issue;
    logic                   fetch_v;
    logic [`CPU_ADDR_W-1:0] fetch_pc;
    logic [`CPU_DATA_W-1:0] rdata;

    // new read only when idle, running and not halted
    assign issue = !wait_done && run && !halted;

    // control state
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc        <= '0;
            wait_done <= 1'b0;
            fetch_v   <= 1'b0;
        end else begin
            // valid is a one-cycle pulse after the read
            fetch_v <= issue;
            if (issue) begin
                wait_done <= 1'b1;
            end else if (redir.done) begin
                wait_done <= 1'b0;
                // jump target or next word, 12-bit add wraps at 4095
                if (redir.taken) begin
                    pc <= redir.target;
                end else begin
                    pc <= pc + 1'b1;
                end
            end
        end
    end

    // instruction memory, loaded while run is low
    always_ff @(posedge clk) begin
        if (prog.we && prog.target == PROG_IMEM) begin
            imem[prog.addr] <= prog.data;
        end
        // synchronous read, pc captured alongside the word
        if (issue) begin
            rdata    <= imem[pc];
            fetch_pc <= pc;
        end
    end

    assign fetch.valid = fetch_v;
    assign fetch.pc    = fetch_pc;
    assign fetch.instr = instr_t'(rdata);

endmodule

/* design/instr_decode_reg.sv */
`timescale 1ns/1ps
`include "cpu_macros.svh"

module instr_decode_reg (
    input  logic                clk,
    input  logic                rst_n,
    input  cpu_pkg::fetch_t     fetch,
    output cpu_pkg::exec_cmd_t  cmd
);
    import cpu_pkg::*;

    // held word and its pc
    instr_t                 ir;
    logic [`CPU_ADDR_W-1:0] ir_pc;
    logic                   cmd_v;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cmd_v <= 1'b0;
        end else begin
            cmd_v <= fetch.valid;
        end
    end

    // word and pc captured with each fetch
    always_ff @(posedge clk) begin
        if (fetch.valid) begin
            ir    <= fetch.instr;
            ir_pc <= fetch.pc;
        end
    end

    // decode from the held word
    always_comb begin
        cmd.valid   = cmd_v;
        cmd.pc      = ir_pc;
        cmd.opcode  = ir.addr.opcode;
        cmd.func    = ALU_ADD;
        cmd.operand = '0;
        case (ir.addr.opcode)
            // immediate view with zero extension
            OP_ALUI, OP_ALUB: begin
                cmd.func    = ir.imm.func;
                cmd.operand = {{(`CPU_DATA_W - `CPU_IMM_W){1'b0}}, ir.imm.imm};
            end
            // address view
            OP_LOAD, OP_LDB, OP_STORE, OP_JMP, OP_JZ: begin
                cmd.operand = {{(`CPU_DATA_W - `CPU_ADDR_W){1'b0}}, ir.addr.addr};
            end
            OP_NOP, OP_HALT: begin
                cmd.operand = '0;
            end
            // codes 9..15 run as nop
            default: begin
                cmd.opcode = OP_NOP;
            end
        endcase
    end

endmodule

/* design/alu16.sv */
`timescale 1ns/1ps
`include "cpu_macros.svh"

module alu16 (
    input  cpu_pkg::alu_op_e         op,
    input  logic [`CPU_DATA_W-1:0]   a,
    input  logic [`CPU_DATA_W-1:0]   b,
    output logic [`CPU_DATA_W-1:0]   result
);
    import cpu_pkg::*;

    always_comb begin
        case (op)
            ALU_ADD:  result = a + b;
            ALU_SUB:  result = a - b;
            // low half of the product
            ALU_MUL:  result = a * b;
            // all ones on divide by zero
            ALU_DIV:  result = (b == '0) ? '1 : a / b;
            // shifts and rotates by one, b ignored
            ALU_SHL:  result = a << 1;
            ALU_SHR:  result = a >> 1;
            ALU_ROL:  result = {a[`CPU_DATA_W-2:0], a[`CPU_DATA_W-1]};
            ALU_ROR:  result = {a[0], a[`CPU_DATA_W-1:1]};
            ALU_AND:  result = a & b;
            ALU_OR:   result = a | b;
            ALU_XOR:  result = a ^ b;
            ALU_NOR:  result = ~(a | b);
            ALU_NAND: result = ~(a & b);
            ALU_XNOR: result = ~(a ^ b);
            // compares give 1 or 0
            ALU_GT:   result = {{(`CPU_DATA_W - 1){1'b0}}, a > b};
            ALU_EQ:   result = {{(`CPU_DATA_W - 1){1'b0}}, a == b};
            default:  result = '0;
        endcase
    end

endmodule

/* design/execute_unit.sv */
`timescale 1ns/1ps
`include "cpu_macros.svh"

module execute_unit (
    input  logic                    clk,
    input  logic                    rst_n,
    input  cpu_pkg::exec_cmd_t      cmd,
    input  cpu_pkg::prog_wr_t       prog,
    output cpu_pkg::redirect_t      redir,
    output logic                    halted,
    output logic [`CPU_DATA_W-1:0]  acc,
    output cpu_pkg::store_t         st
);
    import cpu_pkg::*;

    logic [`CPU_DATA_W-1:0] dmem [`CPU_MEM_DEPTH];
    logic [`CPU_DATA_W-1:0] b_reg;
    logic [`CPU_DATA_W-1:0] dmem_q;
    logic [`CPU_DATA_W-1:0] alu_b;
    logic [`CPU_DATA_W-1:0] alu_y;
    logic [`CPU_ADDR_W-1:0] mem_addr;
    // load in flight, finishes next cycle
    logic                   ld_pend;
    // load destination is b, not acc
    logic                   ld_to_b;
    logic                   is_load;
    logic                   is_alu;
    logic                   is_store;

    assign mem_addr = cmd.operand[`CPU_ADDR_W-1:0];
    assign is_load  = cmd.valid && (cmd.opcode == OP_LOAD || cmd.opcode == OP_LDB);
    assign is_alu   = cmd.valid && (cmd.opcode == OP_ALUI || cmd.opcode == OP_ALUB);
    assign is_store = cmd.valid && cmd.opcode == OP_STORE;

    // second operand, b register or immediate
    assign alu_b = (cmd.opcode == OP_ALUB) ? b_reg : cmd.operand;

    alu16 alu_i (
        .op     (cmd.func),
        .a      (acc),
        .b      (alu_b),
        .result (alu_y)
    );

    // done same cycle, except loads wait one for the read
    assign redir.done   = (cmd.valid && !is_load) || ld_pend;
    assign redir.taken  = cmd.valid &&
                          (cmd.opcode == OP_JMP || (cmd.opcode == OP_JZ && acc == '0));
    assign redir.target = mem_addr;

    // store event, data is acc at execute time
    assign st.valid = is_store;
    assign st.addr  = mem_addr;
    assign st.data  = acc;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            acc     <= '0;
            b_reg   <= '0;
            halted  <= 1'b0;
            ld_pend <= 1'b0;
            ld_to_b <= 1'b0;
        end else begin
            ld_pend <= is_load;
            if (is_load) begin
                ld_to_b <= (cmd.opcode == OP_LDB);
            end
            if (is_alu) begin
                acc <= alu_y;
            end
            // read data arrives one cycle after the command
            if (ld_pend) begin
                if (ld_to_b) begin
                    b_reg <= dmem_q;
                end else begin
                    acc <= dmem_q;
                end
            end
            // sticky until reset
            if (cmd.valid && cmd.opcode == OP_HALT) begin
                halted <= 1'b1;
            end
        end
    end

    // data memory, store wins over the prog port
    always_ff @(posedge clk) begin
        if (is_store) begin
            dmem[mem_addr] <= acc;
        end else if (prog.we && prog.target == PROG_DMEM) begin
            dmem[prog.addr] <= prog.data;
        end
        if (is_load) begin
            dmem_q <= dmem[mem_addr];
        end
    end

endmodule

/* design/cpu_core.sv */
`timescale 1ns/1ps
`include "cpu_macros.svh"

module cpu_core (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    run,
    input  cpu_pkg::prog_wr_t       prog,
    output logic                    halted,
    output logic [`CPU_DATA_W-1:0]  acc,
    output cpu_pkg::store_t         st
);
    import cpu_pkg::*;

    // fetch to decode
    fetch_t    fetch;
    // decode to execute
    exec_cmd_t cmd;
    // execute back to fetch
    redirect_t redir;

    fetch_unit fetch_i (
        .clk    (clk),
        .rst_n  (rst_n),
        .run    (run),
        .halted (halted),
        .redir  (redir),
        .prog   (prog),
        .fetch  (fetch)
    );

    instr_decode_reg decode_i (
        .clk   (clk),
        .rst_n (rst_n),
        .fetch (fetch),
        .cmd   (cmd)
    );

    // owns acc, b, alu and data memory
    execute_unit execute_i (
        .clk    (clk),
        .rst_n  (rst_n),
        .cmd    (cmd),
        .prog   (prog),
        .redir  (redir),
        .halted (halted),
        .acc    (acc),
        .st     (st)
    );

endmodule

/* tests/cpu_core_props.sv */
`timescale 1ns/1ps

module cpu_core_props (
    input logic                clk,
    input logic                rst_n,
    input logic                halted,
    input cpu_pkg::fetch_t     fetch,
    input cpu_pkg::exec_cmd_t  cmd,
    input cpu_pkg::redirect_t  redir,
    input cpu_pkg::store_t     st
);
    import cpu_pkg::*;

    // decode adds exactly one cycle and carries the fetched pc
    a_cmd_after_fetch: assert property (@(posedge clk) disable iff (!rst_n)
        fetch.valid |=> cmd.valid && cmd.pc == $past(fetch.pc))
        else $error("command valid or pc did not follow fetch valid");

    // loads finish one cycle late and everything else at once
    a_done_after_cmd: assert property (@(posedge clk) disable iff (!rst_n)
        cmd.valid |-> ##[0:1] redir.done)
        else $error("no done after a command");

    a_no_fetch_halted: assert property (@(posedge clk) disable iff (!rst_n)
        halted |-> !fetch.valid)
        else $error("fetch while halted");

    // a store only comes from a fetched store word
    a_store_has_cmd: assert property (@(posedge clk) disable iff (!rst_n)
        st.valid |-> $past(fetch.valid) && $past(fetch.instr.addr.opcode) == OP_STORE)
        else $error("store without a fetched store command");

endmodule

bind cpu_core cpu_core_props props_i (
    .clk    (clk),
    .rst_n  (rst_n),
    .halted (halted),
    .fetch  (fetch),
    .cmd    (cmd),
    .redir  (redir),
    .st     (st)
);

/* tests/cpu_core_tb.sv */
`timescale 1ns/1ps
`include "cpu_macros.svh"

module cpu_core_tb;
    import cpu_pkg::*;

    logic                   clk = 1'b0;
    logic                   rst_n;
    logic                   run;
    prog_wr_t               prog;
    logic                   halted;
    logic [`CPU_DATA_W-1:0] acc;
    store_t                 st;

    // program images kept in step with prog writes
    logic [`CPU_DATA_W-1:0] imem_img [`CPU_MEM_DEPTH];
    logic [`CPU_DATA_W-1:0] dmem_img [`CPU_MEM_DEPTH];
    // model copy of data memory updated by stores
    logic [`CPU_DATA_W-1:0] ref_d [`CPU_MEM_DEPTH];
    store_t                 exp_st [$];
    logic [`CPU_DATA_W-1:0] exp_acc;
    logic [31:0]            lfsr;
    logic [`CPU_ADDR_W-1:0] pc_w;
    logic                   active = 1'b0;
    int                     cycles;
    int                     limit;
    int                     n_mismatch = 0;
    int                     n_other = 0;

    always #5 clk = ~clk;

    cpu_core cpu_core_i (
        .clk    (clk),
        .rst_n  (rst_n),
        .run    (run),
        .prog   (prog),
        .halted (halted),
        .acc    (acc),
        .st     (st)
    );

    // fibonacci lfsr taps 32 22 2 1 stepped once per bit
    function automatic logic [15:0] rand_bits(input int n);
        logic [15:0] r;
        logic        fb;
        int          i;
        r = '0;
        for (i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r    = {r[14:0], fb};
        end
        return r;
    endfunction

    // alu functions 0..15 from add through eq
    function automatic logic [15:0] ref_alu(input logic [3:0] f, input logic [15:0] x,
                                            input logic [15:0] y);
        logic [31:0] p;
        p = x * y;
        case (f)
            4'd0:  return x + y;
            4'd1:  return x - y;
            4'd2:  return p[15:0];
            4'd3:  return (y == 16'h0) ? 16'hffff : x / y;
            4'd4:  return {x[14:0], 1'b0};
            4'd5:  return {1'b0, x[15:1]};
            4'd6:  return {x[14:0], x[15]};
            4'd7:  return {x[0], x[15:1]};
            4'd8:  return x & y;
            4'd9:  return x | y;
            4'd10: return x ^ y;
            4'd11: return ~(x | y);
            4'd12: return ~(x & y);
            4'd13: return ~(x ^ y);
            4'd14: return (x > y) ? 16'h1 : 16'h0;
            default: return (x == y) ? 16'h1 : 16'h0;
        endcase
    endfunction

    // interprets the images and counts executed instructions
    function automatic int ref_run();
        logic [15:0] a;
        logic [15:0] b;
        logic [15:0] w;
        logic [11:0] pc;
        logic [11:0] npc;
        store_t      s;
        int          n;
        bit          stop;
        a = '0;
        b = '0;
        pc = '0;
        n = 0;
        stop = 1'b0;
        ref_d = dmem_img;
        exp_st.delete();
        while (!stop && n < 4000) begin
            w   = imem_img[pc];
            npc = pc + 12'd1;
            n++;
            case (w[15:12])
                4'd1: a = ref_alu(w[11:8], a, {8'h00, w[7:0]});
                4'd2: a = ref_alu(w[11:8], a, b);
                4'd3: a = ref_d[w[11:0]];
                4'd4: b = ref_d[w[11:0]];
                4'd5: begin
                    s = {1'b1, w[11:0], a};
                    exp_st.push_back(s);
                    ref_d[w[11:0]] = a;
                end
                4'd6: npc = w[11:0];
                4'd7: begin
                    if (a == 16'h0) npc = w[11:0];
                end
                4'd8: stop = 1'b1;
                // 0 and 9..15 do nothing
                default: ;
            endcase
            pc = npc;
        end
        exp_acc = a;
        return n;
    endfunction

    task automatic check_store(input store_t got, input store_t exp);
        if (got.addr !== exp.addr || got.data !== exp.data) begin
            $display("mismatch st: got addr %h data %h, expected addr %h data %h",
                     got.addr, got.data, exp.addr, exp.data);
            n_mismatch++;
        end
    endtask

    task automatic check_word(input string name, input logic [`CPU_DATA_W-1:0] got,
                              input logic [`CPU_DATA_W-1:0] exp);
        if (got !== exp) begin
            $display("mismatch %s: got %h expected %h", name, got, exp);
            n_mismatch++;
        end
    endtask

    task automatic end_run();
        $display("errors: %0d mismatches, %0d other failures", n_mismatch, n_other);
        if (n_mismatch + n_other == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    endtask

    // one prog write with the image kept in step
    task automatic put(input logic tgt, input logic [11:0] addr, input logic [15:0] data);
        @(posedge clk);
        prog <= {1'b1, tgt, addr, data};
        if (tgt) dmem_img[addr] = data;
        else imem_img[addr] = data;
    endtask

    task automatic emit(input logic [15:0] w);
        put(1'b0, pc_w, w);
        pc_w = pc_w + 12'd1;
    endtask

    task automatic do_reset();
        @(posedge clk);
        rst_n <= 1'b0;
        run   <= 1'b0;
        prog  <= '0;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        pc_w = '0;
    endtask

    task automatic run_prog();
        int steps;
        steps  = ref_run();
        limit  = 5 * steps + 50;
        cycles = 0;
        @(posedge clk);
        prog   <= '0;
        run    <= 1'b1;
        active = 1'b1;
        while (!halted) @(negedge clk);
        // idle cycles where acc must hold and no store may show up
        repeat (8) @(negedge clk);
        check_word("acc", acc, exp_acc);
        if (!halted) begin
            $display("error: halted dropped before the next reset");
            n_other++;
        end
        if (exp_st.size() != 0) begin
            $display("error: %0d expected stores never appeared", exp_st.size());
            n_other++;
        end
        active = 1'b0;
        @(posedge clk);
        run <= 1'b0;
    endtask

    // store compare and timeout sampled mid-cycle
    always @(negedge clk) begin
        if (active) begin
            cycles++;
            if (st.valid) begin
                if (exp_st.size() == 0) begin
                    $display("error: unexpected store to address %h", st.addr);
                    n_other++;
                end else begin
                    check_store(st, exp_st.pop_front());
                end
            end
            if (cycles > limit) begin
                $display("error: cpu did not halt within %0d cycles", limit);
                n_other++;
                end_run();
            end
        end
    end

    initial begin
        int          i;
        logic [15:0] v;
        rst_n = 1'b0;
        run   = 1'b0;
        prog  = '0;
        lfsr  = 32'hc51c_75ea;

        // sixteen alui functions on random acc and immediate
        do_reset();
        for (i = 0; i < 16; i++) begin
            put(1'b1, 12'(16 + i), rand_bits(16));
            emit({OP_LOAD, 12'(16 + i)});
            emit({OP_ALUI, 4'(i), 8'(rand_bits(8))});
            emit({OP_STORE, 12'(100 + i)});
        end
        emit({OP_HALT, 12'h0});
        run_prog();

        // alub with b from ldb including div by zero and an equal pair
        do_reset();
        for (i = 0; i < 16; i++) begin
            v = rand_bits(16);
            put(1'b1, 12'(200 + i), v);
            if (i == 3) put(1'b1, 12'(300 + i), 16'h0);
            else if (i == 15) put(1'b1, 12'(300 + i), v);
            else put(1'b1, 12'(300 + i), rand_bits(16));
            emit({OP_LOAD, 12'(200 + i)});
            emit({OP_LDB, 12'(300 + i)});
            emit({OP_ALUB, 4'(i), 8'h00});
            emit({OP_STORE, 12'(400 + i)});
        end
        emit({OP_HALT, 12'h0});
        run_prog();

        // load, change, store, then read stored words back
        do_reset();
        for (i = 0; i < 4; i++) begin
            put(1'b1, 12'(500 + i), rand_bits(16));
            emit({OP_LOAD, 12'(500 + i)});
            emit({OP_ALUI, ALU_XOR, 8'(rand_bits(8))});
            emit({OP_STORE, 12'(600 + i)});
            emit({OP_LOAD, 12'(600 + i)});
            emit({OP_ALUI, ALU_ADD, 8'h01});
            emit({OP_STORE, 12'(610 + i)});
        end
        emit({OP_HALT, 12'h0});
        run_prog();

        // jz not taken then jmp then jz taken so 701 and 702 are skipped
        do_reset();
        emit({OP_ALUI, ALU_ADD, 8'h05});
        emit({OP_JZ, 12'd4});
        emit({OP_STORE, 12'd700});
        emit({OP_JMP, 12'd5});
        emit({OP_STORE, 12'd701});
        emit({OP_ALUI, ALU_SUB, 8'h05});
        emit({OP_JZ, 12'd8});
        emit({OP_STORE, 12'd702});
        emit({OP_STORE, 12'd703});
        emit({OP_HALT, 12'h0});
        run_prog();

        // codes 9..15 as nop and nothing runs past halt
        do_reset();
        emit({OP_ALUI, ALU_ADD, 8'h33});
        for (i = 9; i < 16; i++) begin
            emit({4'(i), 12'(rand_bits(12))});
        end
        emit({OP_STORE, 12'd710});
        emit({OP_HALT, 12'h0});
        emit({OP_STORE, 12'd711});
        run_prog();

        // random program of 40 instructions
        do_reset();
        for (i = 0; i < 16; i++) begin
            put(1'b1, 12'(800 + i), rand_bits(16));
        end
        for (i = 0; i < 40; i++) begin
            case (rand_bits(2))
                0: emit({OP_ALUI, 4'(rand_bits(4)), 8'(rand_bits(8))});
                1: emit({OP_ALUB, 4'(rand_bits(4)), 8'(rand_bits(8))});
                2: emit({OP_LDB, 12'(800 + rand_bits(4))});
                default: emit({OP_STORE, 12'(800 + rand_bits(4))});
            endcase
        end
        emit({OP_HALT, 12'h0});
        run_prog();

        end_run();
    end

endmodule

/* sources.f */
+incdir+design
design/cpu_pkg.sv
design/fetch_unit.sv
design/instr_decode_reg.sv
design/alu16.sv
design/execute_unit.sv
design/cpu_core.sv
tests/cpu_core_props.sv
tests/cpu_core_tb.sv
